// File: verification/video_testdata.txt
# W addr data bresp | B addr data hold bresp | R addr rdata rresp
# F frames | P x y rgb | all fields hex
R 000 00000000 0
R 004 00000000 0
R 008 00000000 0
W 000 00000005 0
R 000 00000005 0
W 004 00000013 0
R 004 00000013 0
W 008 0000001f 0
R 008 0000001f 0
W 004 00000000 0
W 008 00000000 0
W 000 00000000 0
W 300 00001234 2
R 300 00000000 2
W 104 00000007 0
R 104 00000000 0
W 200 000000a5 0
F 2
P 00 00 00aa55
P 10 07 00aa55
P 1f 0f 00aa55
W 100 00000003 0
W 124 0000000a 0
W 17c 00000005 0
W 1fc 00000006 0
W 24c 00000123 0
W 268 00000abc 0
W 254 000005e7 0
W 258 000009c4 0
W 000 00000003 0
F 2
P 00 00 112233
P 03 03 112233
P 05 06 aabbcc
P 1f 0f 55ee77
B 004 0000001c 3 0
W 008 0000001c 0
R 004 0000001c 0
R 008 0000001c 0
F 2
P 00 00 99cc44
P 04 04 112233
P 09 0a aabbcc

// File: sources.f
+incdir+hw
hw/video_bus_pkg.sv
hw/video_raster_pkg.sv
hw/video_timing.sv
hw/video_mmr.sv
hw/video_tile_render.sv
hw/video_line_buffer.sv
hw/video_palette_out.sv
hw/video_top.sv
verification/video_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tile video testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps \
    --top-module video_tb -f sources.f -o video_tb_sim
./obj_dir/video_tb_sim

// File: verification/video_tb.sv
// Testbench for the tile video subsystem
// Replays AXI4-Lite accesses and pixel checks from a data file
`include "video_macros.svh"

module video_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import video_bus_pkg::*;
    import video_raster_pkg::*;

    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int BUS_TIMEOUT  = 50;

    logic      clk;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    pxl_out_t  pxl;

    video_top UUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .axil_req ( axil_req ),
        .axil_rsp ( axil_rsp ),
        .pxl      ( pxl      )
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            $display("Malformed line in the test data file");
            abort_run();
        end
    endtask

    // Write with bready held off for hold cycles after bvalid
    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                             input int hold, input logic [1:0] exp_resp);
        int cycles;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.bready  = (hold == 0);
        // No response pending, so both ready lines answer at once
        #1;
        check_value("awready", 32'(axil_rsp.awready), 32'd1);
        check_value("wready", 32'(axil_rsp.wready), 32'd1);
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            if (cycles == BUS_TIMEOUT)
                report_timeout("a write response");
            cycles++;
            @(negedge clk);
        end
        // Ready pulse is over while the response is pending
        check_value("awready", 32'(axil_rsp.awready), 32'd0);
        check_value("wready", 32'(axil_rsp.wready), 32'd0);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        check_value("bresp", 32'(axil_rsp.bresp), 32'(exp_resp));
        // Slave has to keep bvalid up while bready is held off
        repeat (hold) begin
            @(negedge clk);
            check_value("bvalid", 32'(axil_rsp.bvalid), 32'd1);
        end
        axil_req.bready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (axil_rsp.bvalid) begin
            if (cycles == BUS_TIMEOUT)
                report_timeout("the write response to clear");
            cycles++;
            @(negedge clk);
        end
        axil_req.bready = 1'b0;
    endtask

    task automatic bus_read(input logic [11:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        int cycles;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        #1;
        check_value("arready", 32'(axil_rsp.arready), 32'd1);
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            if (cycles == BUS_TIMEOUT)
                report_timeout("read data");
            cycles++;
            @(negedge clk);
        end
        check_value("arready", 32'(axil_rsp.arready), 32'd0);
        axil_req.arvalid = 1'b0;
        check_value("rdata", axil_rsp.rdata, exp_data);
        check_value("rresp", 32'(axil_rsp.rresp), 32'(exp_resp));
        cycles = 0;
        @(negedge clk);
        while (axil_rsp.rvalid) begin
            if (cycles == BUS_TIMEOUT)
                report_timeout("the read response to clear");
            cycles++;
            @(negedge clk);
        end
        axil_req.rready = 1'b0;
    endtask

    function automatic bit at_position(input logic [5:0] x, input logic [4:0] y);
        return (pxl.de === 1'b1) && (pxl.pos.x === x) && (pxl.pos.y === y);
    endfunction

    task automatic wait_pixel(input logic [5:0] x, input logic [4:0] y);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!at_position(x, y)) begin
            if (cycles == 2 * FRAME_CYCLES)
                report_timeout("a pixel position");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_frames(input int count);
        repeat (count)
            wait_pixel(6'd0, 5'd0);
    endtask

    task automatic check_pixel(input logic [5:0] x, input logic [4:0] y,
                               input logic [23:0] exp_rgb);
        wait_pixel(x, y);
        check_value("pxl.rgb", 32'(pxl.rgb), 32'(exp_rgb));
    endtask

    initial begin
        int             fd;
        int             n;
        bit             done;
        logic [7:0]     cmd;
        logic [31:0]    f1;
        logic [31:0]    f2;
        logic [31:0]    f3;
        logic [31:0]    f4;
        logic [1023:0]  rest;

        clk = 1'b0;
        rst = 1'b1;
        axil_req = '0;
        axil_req.wstrb = 4'hf;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/video_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            abort_run();
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": n = $fgets(rest, fd);
                    "W": begin
                        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        require_fields(n, 3);
                        bus_write(f1[11:0], f2, 0, f3[1:0]);
                    end
                    "B": begin
                        n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                        require_fields(n, 4);
                        bus_write(f1[11:0], f2, int'(f3), f4[1:0]);
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        require_fields(n, 3);
                        bus_read(f1[11:0], f2, f3[1:0]);
                    end
                    "F": begin
                        n = $fscanf(fd, "%h", f1);
                        require_fields(n, 1);
                        wait_frames(int'(f1));
                    end
                    "P": begin
                        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        require_fields(n, 3);
                        check_pixel(f1[5:0], f2[4:0], f3[23:0]);
                    end
                    default: begin
                        $display("Unknown command in the test data file");
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: hw/video_top.sv
// Tile video subsystem top
// Beam timing, CPU registers, tile renderer, line buffer and palette output
module video_top (
    input  logic                       clk,
    input  logic                       rst,
    input  video_bus_pkg::axil_req_t   axil_req,
    output video_bus_pkg::axil_rsp_t   axil_rsp,
    output video_raster_pkg::pxl_out_t pxl
);
    import video_bus_pkg::*;
    import video_raster_pkg::*;

    timing_t     timing;
    scroll_cfg_t cfg;
    mem_wr_t     tile_wr;
    mem_wr_t     pal_wr;
    lbuf_wr_t    lbuf_wr;
    pal_idx_t    rd_idx;

    video_timing u_timing (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .timing   ( timing   )
    );

    video_mmr u_mmr (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .axil_req ( axil_req ),
        .axil_rsp ( axil_rsp ),
        .cfg      ( cfg      ),
        .tile_wr  ( tile_wr  ),
        .pal_wr   ( pal_wr   )
    );

    // Producer side
    video_tile_render u_render (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .timing   ( timing   ),
        .cfg      ( cfg      ),
        .tile_wr  ( tile_wr  ),
        .lbuf_wr  ( lbuf_wr  )
    );

    video_line_buffer u_lbuf (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .timing   ( timing   ),
        .lbuf_wr  ( lbuf_wr  ),
        .rd_idx   ( rd_idx   )
    );

    // Consumer side
    video_palette_out u_pal (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .timing   ( timing   ),
        .rd_idx   ( rd_idx   ),
        .pal_wr   ( pal_wr   ),
        .pxl      ( pxl      )
    );

endmodule

// File: hw/video_palette_out.sv
// Palette output stage
// Looks up 12 bit palette colours and emits 24 bit RGB with position
// two cycles behind the beam
module video_palette_out (
    input  logic                       clk,
    input  logic                       rst,
    input  video_raster_pkg::timing_t  timing,
    input  video_raster_pkg::pal_idx_t rd_idx,
    input  video_bus_pkg::mem_wr_t     pal_wr,
    output video_raster_pkg::pxl_out_t pxl
);
    import video_bus_pkg::*;
    import video_raster_pkg::*;

    logic [11:0] pal_mem [64];
    beam_pos_t   pos_q1;
    beam_pos_t   pos_q2;
    logic        vis_q1;
    logic        de_q2;
    logic [23:0] rgb_q2;

    // Each 4 bit channel doubled into 8 bits
    function automatic logic [23:0] expand(input logic [11:0] colour);
        return {colour[11:8], colour[11:8], colour[7:4], colour[7:4],
                colour[3:0], colour[3:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (pal_wr.we)
            pal_mem[pal_wr.addr] <= pal_wr.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vis_q1 <= 1'b0;
            de_q2  <= 1'b0;
        end else begin
            vis_q1 <= !timing.hb && !timing.vb;
            de_q2  <= vis_q1;
        end
    end

    // Stage 1 waits on the buffer read, stage 2 on the palette read
    always_ff @(posedge clk) begin
        pos_q1 <= timing.pos;
        pos_q2 <= pos_q1;
        rgb_q2 <= vis_q1 ? expand(pal_mem[rd_idx]) : 24'd0;
    end

    assign pxl = '{de: de_q2, pos: pos_q2, rgb: rgb_q2};

endmodule

// File: hw/video_line_buffer.sv
// Ping-pong line buffer
// Renderer fills the back line while the front line is read out by x
`include "video_macros.svh"

module video_line_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  video_raster_pkg::timing_t  timing,
    input  video_raster_pkg::lbuf_wr_t lbuf_wr,
    output video_raster_pkg::pal_idx_t rd_idx
);
    import video_raster_pkg::*;

    pal_idx_t line_mem [2 * `VID_H_VISIBLE];
    logic     sel;
    logic     rd_bank;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sel <= 1'b0;
        else if (timing.line_start)
            sel <= ~sel;
    end

    // At x 0 the swap is not yet registered
    assign rd_bank = sel ^ timing.line_start;

    always_ff @(posedge clk) begin
        if (lbuf_wr.we)
            line_mem[{~sel, lbuf_wr.addr}] <= lbuf_wr.idx;
        rd_idx <= line_mem[{rd_bank, timing.pos.x[4:0]}];
    end

endmodule

// File: hw/video_tile_render.sv
// Tile renderer
// Draws the next video line of the scrolled tile plane into the line buffer
`include "video_macros.svh"

module video_tile_render (
    input  logic                        clk,
    input  logic                        rst,
    input  video_raster_pkg::timing_t   timing,
    input  video_bus_pkg::scroll_cfg_t  cfg,
    input  video_bus_pkg::mem_wr_t      tile_wr,
    output video_raster_pkg::lbuf_wr_t  lbuf_wr
);
    import video_bus_pkg::*;
    import video_raster_pkg::*;

    logic [3:0]    tile_map [`VID_MAP_TILES * `VID_MAP_TILES];
    render_state_e state;
    logic [4:0]    pix_cnt;
    logic [4:0]    line_q;
    scroll_cfg_t   cfg_q;
    logic [4:0]    next_line;
    logic [4:0]    px;
    logic [4:0]    py;
    logic [5:0]    map_addr;
    logic [3:0]    code;

    always_ff @(posedge clk) begin
        if (tile_wr.we)
            tile_map[tile_wr.addr] <= tile_wr.data[3:0];
    end

    assign next_line = (timing.pos.y == 5'(`VID_V_TOTAL - 1)) ? 5'd0 : timing.pos.y + 5'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RENDER_IDLE;
            pix_cnt <= '0;
            line_q  <= '0;
            cfg_q   <= '0;
        end else begin
            case (state)
                RENDER_IDLE: begin
                    if (timing.line_start) begin
                        state   <= RENDER_LINE;
                        pix_cnt <= '0;
                        line_q  <= next_line;
                        // New scroll setup takes effect on a frame boundary
                        if (next_line == 5'd0)
                            cfg_q <= cfg;
                    end
                end
                RENDER_LINE: begin
                    pix_cnt <= pix_cnt + 5'd1;
                    if (pix_cnt == 5'(`VID_H_VISIBLE - 1))
                        state <= RENDER_IDLE;
                end
                default: state <= RENDER_IDLE;
            endcase
        end
    end

    // Plane coordinates wrap at 32 through the 5 bit sums
    assign px       = pix_cnt + cfg_q.hscroll;
    assign py       = line_q + cfg_q.vscroll;
    assign map_addr = {py[4:`VID_TILE_SHIFT], px[4:`VID_TILE_SHIFT]};
    assign code     = tile_map[map_addr];

    always_comb begin
        lbuf_wr.we   = state == RENDER_LINE;
        lbuf_wr.addr = pix_cnt;
        lbuf_wr.idx  = cfg_q.layer_en ? {cfg_q.pal_bank, code} : '0;
    end

endmodule

// File: hw/video_mmr.sv
// Register block of the tile video subsystem
// AXI4-Lite slave with control and scroll registers; tile map and palette
// writes leave as one cycle strobes
`include "video_macros.svh"

module video_mmr (
    input  logic                        clk,
    input  logic                        rst,
    input  video_bus_pkg::axil_req_t    axil_req,
    output video_bus_pkg::axil_rsp_t    axil_rsp,
    output video_bus_pkg::scroll_cfg_t  cfg,
    output video_bus_pkg::mem_wr_t      tile_wr,
    output video_bus_pkg::mem_wr_t      pal_wr
);
    import video_bus_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    mmr_region_e wr_region;
    mmr_region_e rd_region;
    logic        wr_hs;
    logic        rd_hs;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rvalid_q;
    logic [1:0]  rresp_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_word;
    scroll_cfg_t cfg_q;
    logic        tile_we;
    logic        pal_we;
    logic [5:0]  mem_addr_q;
    logic [11:0] mem_data_q;

    function automatic mmr_region_e decode(input logic [11:0] addr);
        mmr_region_e region;
        if (addr == `VID_ADDR_CTRL)
            region = REG_CTRL;
        else if (addr == `VID_ADDR_HSCROLL)
            region = REG_HSCROLL;
        else if (addr == `VID_ADDR_VSCROLL)
            region = REG_VSCROLL;
        else if ((addr & 12'hf00) == `VID_ADDR_TILE_BASE)
            region = REG_TILE;
        else if ((addr & 12'hf00) == `VID_ADDR_PAL_BASE)
            region = REG_PAL;
        else
            region = REG_NONE;
        return region;
    endfunction

    assign wr_region = decode(axil_req.awaddr);
    assign rd_region = decode(axil_req.araddr);

    // A pending response blocks the next transfer
    assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_hs = axil_req.arvalid && !rvalid_q;

    // Tile map and palette are write only
    always_comb begin
        case (rd_region)
            REG_CTRL:    rd_word = {29'd0, cfg_q.pal_bank, cfg_q.layer_en};
            REG_HSCROLL: rd_word = {27'd0, cfg_q.hscroll};
            REG_VSCROLL: rd_word = {27'd0, cfg_q.vscroll};
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
            rvalid_q <= 1'b0;
            rresp_q  <= RESP_OKAY;
            rdata_q  <= '0;
            cfg_q    <= '0;
            tile_we  <= 1'b0;
            pal_we   <= 1'b0;
        end else begin
            tile_we <= wr_hs && (wr_region == REG_TILE);
            pal_we  <= wr_hs && (wr_region == REG_PAL);

            if (wr_hs) begin
                bvalid_q <= 1'b1;
                bresp_q  <= (wr_region == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
                case (wr_region)
                    REG_CTRL: begin
                        cfg_q.layer_en <= axil_req.wdata[0];
                        cfg_q.pal_bank <= axil_req.wdata[2:1];
                    end
                    REG_HSCROLL: cfg_q.hscroll <= axil_req.wdata[4:0];
                    REG_VSCROLL: cfg_q.vscroll <= axil_req.wdata[4:0];
                    default: ;
                endcase
            end else if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_hs) begin
                rvalid_q <= 1'b1;
                rresp_q  <= (rd_region == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
                rdata_q  <= rd_word;
            end else if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Word index and data shared by both memory strobes
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            mem_addr_q <= axil_req.awaddr[7:2];
            mem_data_q <= axil_req.wdata[11:0];
        end
    end

    always_comb begin
        axil_rsp.awready = wr_hs;
        axil_rsp.wready  = wr_hs;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = rd_hs;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    assign cfg     = cfg_q;
    assign tile_wr = '{we: tile_we, addr: mem_addr_q, data: mem_data_q};
    assign pal_wr  = '{we: pal_we, addr: mem_addr_q, data: mem_data_q};

endmodule

// File: hw/video_timing.sv
// Beam timing generator
// Free running pixel and line counters with blanking and line/frame markers
`include "video_macros.svh"

module video_timing (
    input  logic                      clk,
    input  logic                      rst,
    output video_raster_pkg::timing_t timing
);
    import video_raster_pkg::*;

    logic [5:0] h_cnt;
    logic [4:0] v_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 6'(`VID_H_TOTAL - 1)) begin
            h_cnt <= '0;
            // Wrap to the top after the last blank line
            v_cnt <= (v_cnt == 5'(`VID_V_TOTAL - 1)) ? 5'd0 : v_cnt + 5'd1;
        end else begin
            h_cnt <= h_cnt + 6'd1;
        end
    end

    always_comb begin
        timing.pos.x       = h_cnt;
        timing.pos.y       = v_cnt;
        timing.hb          = h_cnt >= 6'(`VID_H_VISIBLE);
        timing.vb          = v_cnt >= 5'(`VID_V_VISIBLE);
        timing.line_start  = h_cnt == 6'd0;
        timing.frame_start = (h_cnt == 6'd0) && (v_cnt == 5'd0);
    end

endmodule

// File: hw/video_raster_pkg.sv
// Video side types of the tile video subsystem
// Beam position, timing markers, line buffer writes and pixel output
package video_raster_pkg;

    typedef struct packed {
        logic [5:0] x;
        logic [4:0] y;
    } beam_pos_t;

    typedef struct packed {
        beam_pos_t pos;
        logic      hb;
        logic      vb;
        logic      line_start;
        logic      frame_start;
    } timing_t;

    typedef logic [5:0] pal_idx_t;

    typedef struct packed {
        logic       we;
        logic [4:0] addr;
        pal_idx_t   idx;
    } lbuf_wr_t;

    // Red in rgb[23:16], blue in rgb[7:0]
    typedef struct packed {
        logic        de;
        beam_pos_t   pos;
        logic [23:0] rgb;
    } pxl_out_t;

    typedef enum logic {
        RENDER_IDLE,
        RENDER_LINE
    } render_state_e;

endpackage

// File: hw/video_bus_pkg.sv
// CPU side types of the tile video subsystem
// AXI4-Lite request and response, register decode and layer configuration
package video_bus_pkg;

    typedef struct packed {
        logic        awvalid;
        logic [11:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [11:0] araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef enum logic [2:0] {
        REG_CTRL,
        REG_HSCROLL,
        REG_VSCROLL,
        REG_TILE,
        REG_PAL,
        REG_NONE
    } mmr_region_e;

    typedef struct packed {
        logic       layer_en;
        logic [1:0] pal_bank;
        logic [4:0] hscroll;
        logic [4:0] vscroll;
    } scroll_cfg_t;

    // Tile map writes only use data[3:0]
    typedef struct packed {
        logic        we;
        logic [5:0]  addr;
        logic [11:0] data;
    } mem_wr_t;

endpackage

// File: hw/video_macros.svh
// Tile video raster and memory map constants
// Raster size, scroll plane geometry and CPU register addresses
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Raster in pixels and lines
`define VID_H_TOTAL      48
`define VID_H_VISIBLE    32
`define VID_V_TOTAL      20
`define VID_V_VISIBLE    16

// Scroll plane geometry
`define VID_TILE_SHIFT   2
`define VID_MAP_TILES    8

// Register map, byte addresses
`define VID_ADDR_CTRL       12'h000
`define VID_ADDR_HSCROLL    12'h004
`define VID_ADDR_VSCROLL    12'h008
`define VID_ADDR_TILE_BASE  12'h100
`define VID_ADDR_PAL_BASE   12'h200

`endif
